/* source/fpu_types_pkg.sv */
package fpu_types_pkg;

	typedef logic [31:0] word_t; // also a single precision value
	typedef logic [1:0] rmode_t;
	typedef logic [4:0] fpu_flags_t; // V Z O U I
	typedef logic [5:0] fpu_cause_t; // E V Z O U I

	typedef struct packed
	{
		logic [7:0] fcc;
		logic fs;
		fpu_cause_t cause;
		fpu_flags_t enables;
		fpu_flags_t flags;
		rmode_t rm;
	} fcsr_t;

	typedef struct packed
	{
		logic invalid;
		logic unimpl;
	} fpu_except_t;

	typedef enum logic [3:0]
	{
		op_nop,
		op_mtc,
		op_mfc,
		op_ctc,
		op_cfc,
		op_neg,
		op_abs,
		op_cond,
		op_ceil,
		op_floor,
		op_trunc,
		op_round,
		op_cvts,
		op_cvtw,
		op_invalid
	} fpu_op_t;

	localparam word_t fir_value = 32'h0001_0000; // single precision only
	localparam word_t int_invalid = 32'h7fff_ffff;
	localparam int flag_v = 4;

	localparam rmode_t rm_near = 2'd0;
	localparam rmode_t rm_trunc = 2'd1;
	localparam rmode_t rm_ceil = 2'd2;
	localparam rmode_t rm_floor = 2'd3;

endpackage

/* source/fpu_inst_pkg.sv */
package fpu_inst_pkg;

	typedef logic [31:0] inst_t;
	typedef logic [4:0] creg_t; // fs field, inst[15:11]
	typedef logic [2:0] fcc_idx_t; // inst[10:8]
	typedef logic [3:0] cond_mask_t; // un gt lt eq

	typedef struct packed
	{
		fpu_types_pkg::fpu_op_t op;
		creg_t creg;
		fcc_idx_t fcc_idx;
		cond_mask_t cond_mask;
		fpu_types_pkg::rmode_t cvt_mode;
	} issue_t;

	localparam creg_t creg_fir = 5'd0;
	localparam creg_t creg_fccr = 5'd25;
	localparam creg_t creg_fexr = 5'd26;
	localparam creg_t creg_fenr = 5'd28;
	localparam creg_t creg_fcsr = 5'd31;

	// cycles taken by C.cond
	localparam int compare_latency = 2;

	localparam cond_mask_t cond_un = 4'b1000;
	localparam cond_mask_t cond_gt = 4'b0100;
	localparam cond_mask_t cond_lt = 4'b0010;
	localparam cond_mask_t cond_eq = 4'b0001;

endpackage

/* source/fpu_issue.sv */
module fpu_issue(
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  fpu_types_pkg::fpu_op_t op,
	input  fpu_inst_pkg::inst_t inst,
	output fpu_inst_pkg::issue_t issue,
	output logic is_busy,
	output logic commit
);
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	localparam int stage_w = compare_latency - 1;

	logic [2:0] latency;
	logic [stage_w-1:0] stage; // one-hot, bit 0 marks the last cycle

	always_comb
	begin
		case (op)
			op_cond: latency = 3'(compare_latency);
			default: latency = 3'd1;
		endcase
	end

	assign is_busy = (latency > 3'd1) && !stage[0];
	assign commit = !is_busy && !flush;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stage <= '0;
		else if (flush)
			stage <= '0;
		else if (stage != '0)
			stage <= stage >> 1;
		else if (latency > 3'd1)
			stage <= stage_w'(1) << (latency - 3'd2); // reload, also for a held op
	end

	always_comb
	begin
		issue.op = op;
		issue.creg = inst[15:11];
		issue.fcc_idx = inst[10:8];
		issue.cond_mask = '0;
		if (inst[0])
			issue.cond_mask = issue.cond_mask | cond_un;
		if (inst[1])
			issue.cond_mask = issue.cond_mask | cond_eq;
		if (inst[2])
			issue.cond_mask = issue.cond_mask | cond_lt;

		case (op)
			op_ceil: issue.cvt_mode = rm_ceil;
			op_floor: issue.cvt_mode = rm_floor;
			op_trunc: issue.cvt_mode = rm_trunc;
			default: issue.cvt_mode = rm_near; // cvtw takes fcsr rm instead
		endcase
	end

endmodule

/* source/fpu_compare.sv */
module fpu_compare(
	input  logic clk,
	input  logic rst_n,
	input  fpu_types_pkg::word_t reg1,
	input  fpu_types_pkg::word_t reg2,
	input  fpu_inst_pkg::issue_t issue,
	input  logic [7:0] fcc_cur,
	output logic [7:0] fcc_next
);
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	logic nan1;
	logic nan2;
	logic both_zero;
	word_t key1;
	word_t key2;
	cond_mask_t order;
	logic [7:0] fcc_d;

	assign nan1 = (reg1[30:23] == 8'hff) && (reg1[22:0] != '0);
	assign nan2 = (reg2[30:23] == 8'hff) && (reg2[22:0] != '0);
	assign both_zero = (reg1[30:0] == '0) && (reg2[30:0] == '0); // +0 == -0

	// sign-magnitude mapped to an unsigned order
	assign key1 = reg1[31] ? ~reg1 : {1'b1, reg1[30:0]};
	assign key2 = reg2[31] ? ~reg2 : {1'b1, reg2[30:0]};

	always_comb
	begin
		if (nan1 || nan2)
			order = cond_un;
		else if (both_zero || key1 == key2)
			order = cond_eq;
		else if (key1 < key2)
			order = cond_lt;
		else
			order = cond_gt;
	end

	always_comb
	begin
		fcc_d = fcc_cur;
		fcc_d[issue.fcc_idx] = |(order & issue.cond_mask);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fcc_next <= '0;
		else
			fcc_next <= fcc_d;
	end

endmodule

/* source/fpu_convert.sv */
module fpu_convert(
	input  fpu_types_pkg::word_t reg1,
	input  fpu_inst_pkg::issue_t issue,
	input  logic [1:0] rm,
	output fpu_types_pkg::word_t cvt_ret,
	output logic cvt_invalid
);
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	logic sign;
	logic [7:0] expo;
	logic [23:0] sig;
	rmode_t mode;
	logic [63:0] fixed;
	logic [31:0] int_part;
	logic half;
	logic rest;
	logic inexact;
	logic round_up;
	logic [32:0] mag;
	logic big;
	logic range_err;
	logic f2i_op;
	word_t int_ret;
	word_t s_mag;
	word_t s_norm;
	logic [4:0] lead;
	logic s_up;
	word_t s_ret;

	assign sign = reg1[31];
	assign expo = reg1[30:23];
	assign sig = {expo != 8'd0, reg1[22:0]};
	assign mode = (issue.op == op_cvtw) ? rm : issue.cvt_mode;
	assign f2i_op = issue.op inside {op_ceil, op_floor, op_trunc, op_round, op_cvtw};

	// magnitude scaled by 2^32, exact for exponents 118 to 158
	assign fixed = (expo >= 8'd118) ? ({40'd0, sig} << (expo - 8'd118)) : 64'd0;
	assign int_part = fixed[63:32];
	assign half = fixed[31];
	assign rest = (|fixed[30:0]) || (expo < 8'd118 && sig != '0);
	assign inexact = half || rest;

	always_comb
	begin
		case (mode)
			rm_near: round_up = half && (rest || int_part[0]); // ties to even
			rm_ceil: round_up = !sign && inexact;
			rm_floor: round_up = sign && inexact;
			default: round_up = 1'b0;
		endcase
	end

	assign mag = {1'b0, int_part} + 33'(round_up);

	// nan, inf and anything at or beyond 2^31 apart from -2^31
	assign big = (expo > 8'd158) || (expo == 8'd158 && reg1[22:0] != '0);
	assign range_err = big || (sign ? (mag > 33'h0_8000_0000) : (mag > 33'h0_7fff_ffff));
	assign int_ret = range_err ? int_invalid : (sign ? -mag[31:0] : mag[31:0]);

	// word to single
	assign s_mag = sign ? -reg1 : reg1;

	always_comb
	begin
		lead = 5'd0;
		for (int i = 0; i < 32; i++)
		begin
			if (s_mag[i])
				lead = 5'(i);
		end
	end

	assign s_norm = s_mag << (5'd31 - lead);
	assign s_up = s_norm[7] && ((|s_norm[6:0]) || s_norm[8]);

	// mantissa carry rolls into the exponent
	assign s_ret = (s_mag == '0) ? 32'd0 :
		{sign, 8'd127 + {3'd0, lead}, s_norm[30:8]} + 32'(s_up);

	assign cvt_ret = (issue.op == op_cvts) ? s_ret : int_ret;
	assign cvt_invalid = f2i_op && range_err;

endmodule

/* source/fpu_writeback.sv */
module fpu_writeback(
	input  logic clk,
	input  logic rst_n,
	input  fpu_inst_pkg::issue_t issue,
	input  logic commit,
	input  fpu_types_pkg::word_t gpr2,
	input  fpu_types_pkg::word_t reg1,
	input  fpu_types_pkg::word_t reg2,
	input  logic [7:0] fcc_next,
	input  fpu_types_pkg::word_t cvt_ret,
	input  logic cvt_invalid,
	output logic [1:0] rm,
	output fpu_types_pkg::fcsr_t fcsr,
	output fpu_types_pkg::word_t fpu_ret,
	output fpu_types_pkg::word_t cpu_ret,
	output fpu_types_pkg::fpu_except_t except
);
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	fcsr_t fcsr_d;
	word_t fccr_word;
	word_t fexr_word;
	word_t fenr_word;
	word_t fcsr_word;
	logic reg1_nan;
	logic cvt_op;

	assign rm = fcsr.rm;
	assign reg1_nan = (reg1[30:23] == 8'hff) && (reg1[22:0] != '0);
	assign cvt_op = issue.op inside {op_ceil, op_floor, op_trunc, op_round, op_cvtw, op_cvts};

	assign fccr_word = {24'd0, fcsr.fcc};
	assign fexr_word = {14'd0, fcsr.cause, 5'd0, fcsr.flags, 2'd0};
	assign fenr_word = {20'd0, fcsr.enables, 4'd0, fcsr.fs, fcsr.rm};
	assign fcsr_word = {fcsr.fcc[7:1], fcsr.fs, fcsr.fcc[0], 5'd0,
		fcsr.cause, fcsr.enables, fcsr.flags, fcsr.rm};

	always_comb
	begin
		except = '0;
		case (issue.op)
			op_neg, op_abs: except.invalid = reg1_nan;
			op_invalid: except.unimpl = 1'b1;
			default: except.invalid = cvt_invalid; // only set for float to word
		endcase
	end

	// each update is idempotent while the op is held
	always_comb
	begin
		fcsr_d = fcsr;
		if (issue.op == op_cond)
			fcsr_d.fcc = fcc_next;
		else if (cvt_op || issue.op == op_neg || issue.op == op_abs)
			fcsr_d.flags[flag_v] = fcsr.flags[flag_v] | except.invalid; // sticky
		else if (issue.op == op_ctc)
		begin
			case (issue.creg)
				creg_fccr: fcsr_d.fcc = gpr2[7:0];
				creg_fexr:
				begin
					fcsr_d.cause = gpr2[17:12];
					fcsr_d.flags = gpr2[6:2];
				end
				creg_fenr:
				begin
					fcsr_d.enables = gpr2[11:7];
					fcsr_d.fs = gpr2[2];
					fcsr_d.rm = gpr2[1:0];
				end
				creg_fcsr: fcsr_d = {gpr2[31:25], gpr2[23], gpr2[24], gpr2[17:12],
					gpr2[11:7], gpr2[6:2], gpr2[1:0]};
				default: fcsr_d = fcsr;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fcsr <= '0;
		else if (commit)
			fcsr <= fcsr_d;
	end

	always_comb
	begin
		case (issue.op)
			op_mtc: fpu_ret = gpr2;
			op_neg: fpu_ret = reg1_nan ? reg1 : {~reg1[31], reg1[30:0]};
			op_abs: fpu_ret = reg1_nan ? reg1 : {1'b0, reg1[30:0]};
			op_ceil, op_floor, op_trunc, op_round, op_cvtw, op_cvts: fpu_ret = cvt_ret;
			default: fpu_ret = '0;
		endcase
	end

	always_comb
	begin
		cpu_ret = '0;
		if (issue.op == op_mfc)
			cpu_ret = reg2;
		else if (issue.op == op_cfc)
		begin
			case (issue.creg)
				creg_fir: cpu_ret = fir_value;
				creg_fccr: cpu_ret = fccr_word;
				creg_fexr: cpu_ret = fexr_word;
				creg_fenr: cpu_ret = fenr_word;
				creg_fcsr: cpu_ret = fcsr_word;
				default: cpu_ret = '0;
			endcase
		end
	end

endmodule

/* source/fpu_ex_top.sv */
module fpu_ex_top(
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  fpu_types_pkg::fpu_op_t op,
	input  fpu_inst_pkg::inst_t inst,
	input  fpu_types_pkg::word_t gpr2,
	input  fpu_types_pkg::word_t reg1,
	input  fpu_types_pkg::word_t reg2,
	output fpu_types_pkg::word_t fpu_ret,
	output fpu_types_pkg::word_t cpu_ret,
	output fpu_types_pkg::fpu_except_t except,
	output logic is_busy,
	output fpu_types_pkg::fcsr_t fcsr
);
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	issue_t issue;
	logic commit;
	logic [7:0] fcc_next;
	word_t cvt_ret;
	logic cvt_invalid;
	logic [1:0] rm;

	fpu_issue u_issue(
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.op(op),
		.inst(inst),
		.issue(issue),
		.is_busy(is_busy),
		.commit(commit)
	);

	fpu_compare u_compare(
		.clk(clk),
		.rst_n(rst_n),
		.reg1(reg1),
		.reg2(reg2),
		.issue(issue),
		.fcc_cur(fcsr.fcc),
		.fcc_next(fcc_next)
	);

	fpu_convert u_convert(
		.reg1(reg1),
		.issue(issue),
		.rm(rm),
		.cvt_ret(cvt_ret),
		.cvt_invalid(cvt_invalid)
	);

	fpu_writeback u_writeback(
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.commit(commit),
		.gpr2(gpr2),
		.reg1(reg1),
		.reg2(reg2),
		.fcc_next(fcc_next),
		.cvt_ret(cvt_ret),
		.cvt_invalid(cvt_invalid),
		.rm(rm),
		.fcsr(fcsr),
		.fpu_ret(fpu_ret),
		.cpu_ret(cpu_ret),
		.except(except)
	);

endmodule

/* test/fpu_ex_properties.sv */
module fpu_ex_properties(
	input  logic clk,
	input  logic rst_n,
	input  logic is_busy,
	input  fpu_types_pkg::fpu_op_t op,
	input  fpu_types_pkg::fpu_except_t except,
	input  fpu_types_pkg::word_t cvt_ret
);
	import fpu_types_pkg::*;

	int failures = 0;
	logic f2i;

	assign f2i = op inside {op_ceil, op_floor, op_trunc, op_round, op_cvtw};

	busy_in_reset: assert property (@(posedge clk) !rst_n |-> !is_busy)
		else
		begin
			$error("is_busy high during reset");
			failures++;
		end

	busy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) is_busy |=> !is_busy)
		else
		begin
			$error("is_busy held longer than one cycle");
			failures++;
		end

	// saturated value goes with invalid
	invalid_value: assert property (@(posedge clk) disable iff (!rst_n)
		f2i && except.invalid |-> cvt_ret == int_invalid)
		else
		begin
			$error("invalid conversion without saturated result");
			failures++;
		end

endmodule

bind fpu_ex_top fpu_ex_properties u_properties(
	.clk(clk),
	.rst_n(rst_n),
	.is_busy(is_busy),
	.op(op),
	.except(except),
	.cvt_ret(cvt_ret)
);

/* test/fpu_ex_tb.sv */
module fpu_ex_tb;
	import fpu_types_pkg::*;
	import fpu_inst_pkg::*;

	logic clk;
	logic rst_n;
	logic flush;
	fpu_op_t op;
	inst_t inst;
	word_t gpr2;
	word_t reg1;
	word_t reg2;
	word_t fpu_ret;
	word_t cpu_ret;
	fpu_except_t except;
	logic is_busy;
	fcsr_t fcsr;
	int errors;
	int timeouts;
	logic [15:0] lfsr;
	logic [7:0] m_fcc; // reference FCSR fields
	logic m_fs;
	logic [5:0] m_cause;
	logic [4:0] m_enables;
	logic [4:0] m_flags;
	logic [1:0] m_rm;

	fpu_ex_top dut(
		.clk(clk), .rst_n(rst_n), .flush(flush), .op(op), .inst(inst), .gpr2(gpr2),
		.reg1(reg1), .reg2(reg2), .fpu_ret(fpu_ret), .cpu_ret(cpu_ret), .except(except),
		.is_busy(is_busy), .fcsr(fcsr)
	);

	always #5 clk = ~clk;

	function automatic word_t rand_bits(input int n);
		word_t v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 16'hb400;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic word_t creg_word(input creg_t n);
		case (n)
			5'd0: return fir_value;
			5'd25: return {24'd0, m_fcc};
			5'd26: return {14'd0, m_cause, 5'd0, m_flags, 2'd0};
			5'd28: return {20'd0, m_enables, 4'd0, m_fs, m_rm};
			5'd31: return {m_fcc[7:1], m_fs, m_fcc[0], 5'd0, m_cause, m_enables, m_flags, m_rm};
			default: return '0;
		endcase
	endfunction

	function automatic fcsr_t model_fcsr();
		return {m_fcc, m_fs, m_cause, m_enables, m_flags, m_rm};
	endfunction

	function automatic logic is_nan(input word_t a);
		return a[30:23] == 8'hff && a[22:0] != '0;
	endfunction

	// 0 unordered, 1 equal, 2 less, 3 greater
	function automatic int order_code(input word_t a, input word_t b);
		if (is_nan(a) || is_nan(b))
			return 0;
		if ((a[30:0] == '0 && b[30:0] == '0) || a == b)
			return 1;
		if (a[31] != b[31])
			return a[31] ? 2 : 3;
		if (a[31])
			return (a[30:0] > b[30:0]) ? 2 : 3;
		return (a[30:0] < b[30:0]) ? 2 : 3;
	endfunction

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic model_ctc(input creg_t n, input word_t d);
		case (n)
			5'd25: m_fcc = d[7:0];
			5'd26: {m_cause, m_flags} = {d[17:12], d[6:2]};
			5'd28: {m_enables, m_fs, m_rm} = {d[11:7], d[2], d[1:0]};
			5'd31: {m_fcc, m_fs, m_cause, m_enables, m_flags, m_rm} =
				{d[31:25], d[23], d[24], d[17:12], d[11:7], d[6:2], d[1:0]};
			default: ;
		endcase
	endtask

	task automatic wait_idle(output int cycles);
		cycles = 0;
		while (cycles < 16)
		begin
			@(negedge clk);
			cycles++;
			if (!is_busy)
				return;
		end
		$display("timeout while waiting for is_busy to fall");
		timeouts++;
	endtask

	task automatic drive(input fpu_op_t o, input inst_t i, input word_t g, input word_t a,
		input word_t b);
		@(negedge clk);
		op = o;
		inst = i;
		gpr2 = g;
		reg1 = a;
		reg2 = b;
	endtask

	task automatic run_op(input string name, input fpu_op_t o, input inst_t i, input word_t g,
		input word_t a, input word_t b, input word_t exp_fpu, input word_t exp_cpu,
		input logic exp_inv, input logic exp_unimpl);
		int cycles;
		drive(o, i, g, a, b);
		wait_idle(cycles);
		check({name, " fpu_ret"}, exp_fpu, fpu_ret);
		check({name, " cpu_ret"}, exp_cpu, cpu_ret);
		check({name, " except"}, {30'd0, exp_inv, exp_unimpl}, {30'd0, except});
		if (o == op_ctc)
			model_ctc(i[15:11], g);
		if (o inside {op_neg, op_abs, op_ceil, op_floor, op_trunc, op_round, op_cvtw, op_cvts})
			m_flags[4] = m_flags[4] | exp_inv; // sticky V
		check({name, " fcsr"}, {5'd0, model_fcsr()}, {5'd0, fcsr});
	endtask

	task automatic run_cond(input word_t a, input word_t b, input fcc_idx_t idx,
		input logic [2:0] c, input logic fl);
		int cycles;
		int ord;
		drive(op_cond, {21'd0, idx, 5'd0, c}, '0, a, b);
		flush = fl;
		#1;
		check("cond busy", 32'd1, {31'd0, is_busy});
		if (fl)
		begin
			@(negedge clk);
			check("flush busy", 32'd1, {31'd0, is_busy}); // counter cleared, op still held
		end
		else
		begin
			wait_idle(cycles);
			check("cond cycles", 32'd1, cycles);
			@(negedge clk); // commit edge
			ord = order_code(a, b);
			m_fcc[idx] = (c[0] && ord == 0) || (c[1] && ord == 1) || (c[2] && ord == 2);
		end
		op = op_nop;
		flush = 1'b0;
		check("cond fcc", {24'd0, m_fcc}, {24'd0, fcsr.fcc});
	endtask

	task automatic test_reset();
		check("reset busy", 32'd0, {31'd0, is_busy});
		run_op("cfc 31", op_cfc, {16'd0, creg_fcsr, 11'd0}, '0, '0, '0, '0, '0, 0, 0);
		run_op("cfc 0", op_cfc, {16'd0, creg_fir, 11'd0}, '0, '0, '0, '0, fir_value, 0, 0);
	endtask

	task automatic test_moves();
		word_t d;
		d = rand_bits(32);
		run_op("mtc", op_mtc, '0, d, '0, '0, d, '0, 0, 0);
		d = rand_bits(32);
		run_op("mfc", op_mfc, '0, '0, '0, d, '0, d, 0, 0);
		run_op("neg", op_neg, '0, '0, 32'h3fc00000, '0, 32'hbfc00000, '0, 0, 0);
		run_op("neg zero", op_neg, '0, '0, 32'h80000000, '0, 32'h00000000, '0, 0, 0);
		run_op("abs", op_abs, '0, '0, 32'hbfc00000, '0, 32'h3fc00000, '0, 0, 0);
		run_op("abs nan", op_abs, '0, '0, 32'h7fc00000, '0, 32'h7fc00000, '0, 1, 0);
		run_op("neg nan", op_neg, '0, '0, 32'hffc00001, '0, 32'hffc00001, '0, 1, 0);
	endtask

	task automatic test_ctrl();
		creg_t regs[5] = '{5'd25, 5'd26, 5'd28, 5'd31, 5'd0};
		word_t d;
		for (int r = 0; r < 4; r++)
		begin
			d = rand_bits(32);
			run_op("ctc", op_ctc, {16'd0, regs[r], 11'd0}, d, '0, '0, '0, '0, 0, 0);
			for (int s = 0; s < 5; s++)
				run_op("cfc", op_cfc, {16'd0, regs[s], 11'd0}, '0, '0, '0, '0,
					creg_word(regs[s]), 0, 0);
		end
	endtask

	task automatic test_compare();
		word_t sp[8] = '{32'h3f800000, 32'h00000000, 32'h7f800000, 32'h80000000,
			32'h7fc00001, 32'hff800000, 32'hbf800000, 32'hffc00000};
		word_t a;
		word_t b;
		word_t idx;
		for (int k = 0; k < 48; k++)
		begin
			a = (k % 24 < 8) ? rand_bits(32) : sp[k % 8];
			b = (k % 24 < 16) ? rand_bits(32) : sp[(k * 3) % 8];
			idx = rand_bits(3);
			run_cond(a, b, idx[2:0], 3'(k), 1'b0);
		end
		// masks picked so that a leaked commit would flip the bit
		run_cond(32'h3f800000, 32'h40000000, 3'd5, m_fcc[5] ? 3'b000 : 3'b100, 1'b1);
		run_cond(32'h3f800000, 32'h40000000, 3'd6, m_fcc[6] ? 3'b001 : 3'b111, 1'b1);
	endtask

	task automatic test_convert();
		run_op("clear flags", op_ctc, {16'd0, creg_fexr, 11'd0}, '0, '0, '0, '0, '0, 0, 0);
		run_op("ceil 2.5", op_ceil, '0, '0, 32'h40200000, '0, 32'd3, '0, 0, 0);
		run_op("floor 2.5", op_floor, '0, '0, 32'h40200000, '0, 32'd2, '0, 0, 0);
		run_op("trunc 2.5", op_trunc, '0, '0, 32'h40200000, '0, 32'd2, '0, 0, 0);
		run_op("round 2.5", op_round, '0, '0, 32'h40200000, '0, 32'd2, '0, 0, 0);
		run_op("round 3.5", op_round, '0, '0, 32'h40600000, '0, 32'd4, '0, 0, 0);
		run_op("ceil -2.5", op_ceil, '0, '0, 32'hc0200000, '0, 32'hfffffffe, '0, 0, 0);
		run_op("floor -2.5", op_floor, '0, '0, 32'hc0200000, '0, 32'hfffffffd, '0, 0, 0);
		run_op("round -0.5", op_round, '0, '0, 32'hbf000000, '0, 32'd0, '0, 0, 0);
		run_op("floor -0.5", op_floor, '0, '0, 32'hbf000000, '0, 32'hffffffff, '0, 0, 0);
		run_op("trunc -2^31", op_trunc, '0, '0, 32'hcf000000, '0, 32'h80000000, '0, 0, 0);
		run_op("round 2^31", op_round, '0, '0, 32'h4f000000, '0, 32'h7fffffff, '0, 1, 0);
		run_op("trunc nan", op_trunc, '0, '0, 32'h7fc00000, '0, 32'h7fffffff, '0, 1, 0);
		run_op("round 1.0", op_round, '0, '0, 32'h3f800000, '0, 32'd1, '0, 0, 0);
		run_op("rm ceil", op_ctc, {16'd0, creg_fenr, 11'd0}, 32'd2, '0, '0, '0, '0, 0, 0);
		run_op("cvtw ceil", op_cvtw, '0, '0, 32'h40200000, '0, 32'd3, '0, 0, 0);
		run_op("rm floor", op_ctc, {16'd0, creg_fenr, 11'd0}, 32'd3, '0, '0, '0, '0, 0, 0);
		run_op("cvtw floor", op_cvtw, '0, '0, 32'h40200000, '0, 32'd2, '0, 0, 0);
		run_op("rm near", op_ctc, {16'd0, creg_fenr, 11'd0}, 32'd0, '0, '0, '0, '0, 0, 0);
		run_op("cvtw near", op_cvtw, '0, '0, 32'h40600000, '0, 32'd4, '0, 0, 0);
		run_op("cvts 1", op_cvts, '0, '0, 32'd1, '0, 32'h3f800000, '0, 0, 0);
		run_op("cvts -1", op_cvts, '0, '0, 32'hffffffff, '0, 32'hbf800000, '0, 0, 0);
		run_op("cvts 0", op_cvts, '0, '0, 32'd0, '0, 32'd0, '0, 0, 0);
		run_op("cvts tie", op_cvts, '0, '0, 32'h01000001, '0, 32'h4b800000, '0, 0, 0);
		run_op("cvts up", op_cvts, '0, '0, 32'h01000003, '0, 32'h4b800002, '0, 0, 0);
		run_op("cvts max", op_cvts, '0, '0, 32'h7fffffff, '0, 32'h4f000000, '0, 0, 0);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		op = op_nop;
		inst = '0;
		gpr2 = '0;
		reg1 = '0;
		reg2 = '0;
		errors = 0;
		timeouts = 0;
		lfsr = 16'd65;
		{m_fcc, m_fs, m_cause, m_enables, m_flags, m_rm} = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_moves();
		test_ctrl();
		test_compare();
		test_convert();
		run_op("unimpl", op_invalid, '0, '0, '0, '0, '0, '0, 0, 1);
		errors = errors + dut.u_properties.failures;
		$display("errors %0d timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* src.f */
source/fpu_types_pkg.sv
source/fpu_inst_pkg.sv
source/fpu_issue.sv
source/fpu_compare.sv
source/fpu_convert.sv
source/fpu_writeback.sv
source/fpu_ex_top.sv
test/fpu_ex_properties.sv
test/fpu_ex_tb.sv

/* run.sh */
#!/bin/sh
# build and run the FPU execute stage testbench
verilator --binary --assert --top-module fpu_ex_tb -f src.f -o fpu_ex_sim || exit 1
out=$(./obj_dir/fpu_ex_sim)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && exit 0 || exit 1
